// File: logic/sram_test_macros.svh
`ifndef SRAM_TEST_MACROS_SVH
`define SRAM_TEST_MACROS_SVH

// SRAM geometry
`define SRAM_ADDR_W 20
`define SRAM_DATA_W 16
`define SRAM_BE_W 2

// ADC sample width, two samples fill one SRAM word
`define ADC_W 8

// capture window
`define CAPTURE_WORDS 64
`define ADC_BASE_ADDR 20'h80000

`endif

// File: logic/sram_test_pkg.sv
`include "sram_test_macros.svh"

package sram_test_pkg;

  typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;
  // active high, one bit per byte lane
  typedef logic [`SRAM_BE_W-1:0] sram_be_t;
  typedef logic [`ADC_W-1:0] adc_sample_t;

  // one SRAM word, seen as host data or as an ADC sample pair
  typedef union packed {
    logic [`SRAM_DATA_W-1:0] word;
    struct packed {
      adc_sample_t hi;
      adc_sample_t lo;
    } pair;
  } sram_word_u;

  typedef enum logic [1:0] {
    st_idle,
    st_capture,
    st_drain,
    st_done
  } capture_state_e;

endpackage

// File: logic/sram_bus_if.sv
`timescale 1ns/1ps

// request side of one SRAM bus master
interface sram_bus_if;

  sram_test_pkg::sram_addr_t address;
  sram_test_pkg::sram_be_t   byteenable;
  logic                      write;
  sram_test_pkg::sram_word_u writedata;
  logic                      read;
  logic                      waitrequest;

  modport master (
    output address,
    output byteenable,
    output write,
    output writedata,
    output read,
    input  waitrequest
  );

  modport arbiter (
    input  address,
    input  byteenable,
    input  write,
    input  writedata,
    input  read,
    output waitrequest
  );

endinterface

// File: logic/capture_fsm.sv
`timescale 1ns/1ps

module capture_fsm (
  input  logic clock,
  input  logic rst_n,
  input  logic adc_enable,
  input  logic last_sample,
  output logic count_en,
  output logic clear,
  output logic busy,
  output logic adc_busy,
  output logic adc_done,
  output logic adc_pwrdwn
);

  sram_test_pkg::capture_state_e state;
  sram_test_pkg::capture_state_e state_next;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= sram_test_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      // enable only counts while idle
      sram_test_pkg::st_idle:    if (adc_enable) state_next = sram_test_pkg::st_capture;
      sram_test_pkg::st_capture: if (last_sample) state_next = sram_test_pkg::st_drain;
      // one cycle for the last packed word to reach the pins
      sram_test_pkg::st_drain:   state_next = sram_test_pkg::st_done;
      default:                   state_next = sram_test_pkg::st_idle;
    endcase
  end

  // restart the sample count as capture begins
  assign clear      = (state == sram_test_pkg::st_idle) && adc_enable;
  assign count_en   = (state == sram_test_pkg::st_capture);
  assign adc_busy   = count_en;
  assign adc_pwrdwn = !count_en;
  assign adc_done   = (state == sram_test_pkg::st_done);

  // bus select, held until the last write has left
  assign busy = (state != sram_test_pkg::st_idle);

endmodule

// File: logic/sample_counter.sv
`timescale 1ns/1ps
`include "sram_test_macros.svh"

module sample_counter (
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic                      count_en,
  input  logic                      clear,
  output logic                      last_sample,
  output logic                      odd_sample,
  output sram_test_pkg::sram_addr_t word_addr
);

  localparam int unsigned SAMPLES = 2 * `CAPTURE_WORDS;
  localparam int unsigned CNT_W = $clog2(SAMPLES);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clock) begin
    if (!rst_n || clear) begin
      count <= '0;
    end else if (count_en) begin
      // wraps to zero after the final sample
      count <= count + 1'b1;
    end
  end

  assign last_sample = (count == CNT_W'(SAMPLES - 1));

  // bit 0 picks the byte of the pair
  assign odd_sample = count[0];

  // remaining bits index words inside the capture window
  assign word_addr = `ADC_BASE_ADDR + sram_test_pkg::sram_addr_t'(count[CNT_W-1:1]);

endmodule

// File: logic/sample_packer.sv
`timescale 1ns/1ps

module sample_packer (
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic                       count_en,
  input  logic                       odd_sample,
  input  sram_test_pkg::sram_addr_t  word_addr,
  input  sram_test_pkg::adc_sample_t adc_data,
  sram_bus_if.master                 bus
);

  // earlier sample of the current pair
  sram_test_pkg::adc_sample_t lo_sample;

  always_ff @(posedge clock) begin
    if (count_en && !odd_sample) begin
      lo_sample <= adc_data;
    end
  end

  // one write per pair, valid for a single cycle
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      bus.write <= 1'b0;
    end else begin
      bus.write <= count_en && odd_sample;
    end
  end

  always_ff @(posedge clock) begin
    if (count_en && odd_sample) begin
      bus.address <= word_addr;
      bus.writedata.pair.hi <= adc_data;
      bus.writedata.pair.lo <= lo_sample;
    end
  end

  // full word every time
  assign bus.byteenable = '1;

  // capture only writes
  assign bus.read = 1'b0;

endmodule

// File: logic/sram_arbiter.sv
`timescale 1ns/1ps

module sram_arbiter (
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic                      busy,
  sram_bus_if.arbiter               cap,
  sram_bus_if.arbiter               host,
  output sram_test_pkg::sram_addr_t sram_addr,
  output sram_test_pkg::sram_word_u sram_dq_out,
  input  sram_test_pkg::sram_word_u sram_dq_in,
  output logic                      sram_dq_oe,
  output logic                      sram_ce_n,
  output logic                      sram_oe_n,
  output logic                      sram_we_n,
  output sram_test_pkg::sram_be_t   sram_be_n,
  output sram_test_pkg::sram_word_u readdata,
  output logic                      readdataready
);

  sram_test_pkg::sram_addr_t sel_address;
  sram_test_pkg::sram_be_t   sel_be;
  sram_test_pkg::sram_word_u sel_wdata;
  logic                      acc_wr;
  logic                      acc_rd;
  logic                      rd_pend;

  // capture owns the bus while busy and is never stalled
  assign cap.waitrequest  = 1'b0;
  assign host.waitrequest = busy;

  always_comb begin
    if (busy) begin
      sel_address = cap.address;
      sel_be      = cap.byteenable;
      sel_wdata   = cap.writedata;
      acc_wr      = cap.write;
      acc_rd      = cap.read && !cap.write;
    end else begin
      sel_address = host.address;
      sel_be      = host.byteenable;
      sel_wdata   = host.writedata;
      acc_wr      = host.write;
      acc_rd      = host.read && !host.write;
    end
  end

  // strobes for the cycle after acceptance
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      sram_ce_n  <= 1'b1;
      sram_oe_n  <= 1'b1;
      sram_we_n  <= 1'b1;
      sram_dq_oe <= 1'b0;
    end else begin
      sram_ce_n  <= !(acc_wr || acc_rd);
      sram_oe_n  <= !acc_rd;
      sram_we_n  <= !acc_wr;
      sram_dq_oe <= acc_wr;
    end
  end

  always_ff @(posedge clock) begin
    if (acc_wr || acc_rd) begin
      sram_addr   <= sel_address;
      sram_dq_out <= sel_wdata;
      sram_be_n   <= ~sel_be;
    end
  end

  // read pipeline
  // stage 1 marks a read on the pins, stage 2 flags captured data
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rd_pend       <= 1'b0;
      readdataready <= 1'b0;
    end else begin
      rd_pend       <= acc_rd;
      readdataready <= rd_pend;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_pend) begin
      readdata <= sram_dq_in;
    end
  end

endmodule

// File: logic/sram_test_sys.sv
`timescale 1ns/1ps

module sram_test_sys (
  input  logic                       clock,
  input  logic                       rst_n,

  // host port
  input  sram_test_pkg::sram_addr_t  host_address,
  input  sram_test_pkg::sram_be_t    host_byteenable,
  input  logic                       host_read,
  input  logic                       host_write,
  input  sram_test_pkg::sram_word_u  host_writedata,
  output sram_test_pkg::sram_word_u  host_readdata,
  output logic                       host_readdataready,
  output logic                       host_waitrequest,

  // ADC
  input  logic                       adc_enable,
  output logic                       adc_done,
  output logic                       adc_busy,
  input  sram_test_pkg::adc_sample_t adc_data,
  output logic                       adc_pwrdwn,

  // SRAM pins, data bus split at the pad
  output sram_test_pkg::sram_addr_t  sram_addr,
  output sram_test_pkg::sram_word_u  sram_dq_out,
  input  sram_test_pkg::sram_word_u  sram_dq_in,
  output logic                       sram_dq_oe,
  output logic                       sram_ce_n,
  output logic                       sram_oe_n,
  output logic                       sram_we_n,
  output sram_test_pkg::sram_be_t    sram_be_n
);

  logic                      count_en;
  logic                      clear;
  logic                      busy;
  logic                      last_sample;
  logic                      odd_sample;
  sram_test_pkg::sram_addr_t word_addr;

  sram_bus_if cap_bus ();
  sram_bus_if host_bus ();

  assign host_bus.address    = host_address;
  assign host_bus.byteenable = host_byteenable;
  assign host_bus.read       = host_read;
  assign host_bus.write      = host_write;
  assign host_bus.writedata  = host_writedata;
  assign host_waitrequest    = host_bus.waitrequest;

  capture_fsm capture_fsm_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .adc_enable  (adc_enable),
    .last_sample (last_sample),
    .count_en    (count_en),
    .clear       (clear),
    .busy        (busy),
    .adc_busy    (adc_busy),
    .adc_done    (adc_done),
    .adc_pwrdwn  (adc_pwrdwn)
  );

  sample_counter sample_counter_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .count_en    (count_en),
    .clear       (clear),
    .last_sample (last_sample),
    .odd_sample  (odd_sample),
    .word_addr   (word_addr)
  );

  sample_packer sample_packer_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .count_en   (count_en),
    .odd_sample (odd_sample),
    .word_addr  (word_addr),
    .adc_data   (adc_data),
    .bus        (cap_bus)
  );

  sram_arbiter sram_arbiter_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .busy          (busy),
    .cap           (cap_bus),
    .host          (host_bus),
    .sram_addr     (sram_addr),
    .sram_dq_out   (sram_dq_out),
    .sram_dq_in    (sram_dq_in),
    .sram_dq_oe    (sram_dq_oe),
    .sram_ce_n     (sram_ce_n),
    .sram_oe_n     (sram_oe_n),
    .sram_we_n     (sram_we_n),
    .sram_be_n     (sram_be_n),
    .readdata      (host_readdata),
    .readdataready (host_readdataready)
  );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic rst_n
);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // reset released just after the third rising edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clock);
    #1 rst_n = 1'b1;
  end

endmodule

// File: sim/sram_test_sys_properties.sv
`timescale 1ns/1ps

module sram_test_sys_properties (
  input logic clock,
  input logic rst_n,
  input logic host_read,
  input logic host_write,
  input logic host_waitrequest,
  input logic host_readdataready,
  input logic adc_done,
  input logic sram_oe_n,
  input logic sram_we_n
);

  // output enable and write enable never overlap on the pins
  assert property (@(posedge clock) disable iff (!rst_n) sram_oe_n || sram_we_n)
    else $error("sram_oe_n and sram_we_n are low in the same cycle");

  assert property (@(posedge clock) disable iff (!rst_n) adc_done |=> !adc_done)
    else $error("adc_done stayed high for more than one cycle");

  // ready comes exactly two edges after an accepted host read
  assert property (@(posedge clock) disable iff (!rst_n)
    host_readdataready == $past(host_read && !host_write && !host_waitrequest, 2))
    else $error("host_readdataready is out of step with the accepted reads");

endmodule

bind sram_test_sys sram_test_sys_properties props_i (
  .clock              (clock),
  .rst_n              (rst_n),
  .host_read          (host_read),
  .host_write         (host_write),
  .host_waitrequest   (host_waitrequest),
  .host_readdataready (host_readdataready),
  .adc_done           (adc_done),
  .sram_oe_n          (sram_oe_n),
  .sram_we_n          (sram_we_n)
);

// File: sim/sram_test_sys_tb.sv
`timescale 1ns/1ps
`include "sram_test_macros.svh"

module sram_test_sys_tb;

  localparam int unsigned SEED = 32'h2fae;
  localparam int unsigned N_WORDS = 16;
  // three captures, one capture readback, host traffic of tests 2 and 3
  localparam int unsigned TEST_CYCLES = 3 * (2 * `CAPTURE_WORDS + 8) + `CAPTURE_WORDS
                                        + 4 * N_WORDS + 20;
  localparam int unsigned TIMEOUT_NS = (TEST_CYCLES + 200) * 4;

  typedef struct {
    sram_test_pkg::sram_word_u data;
    int unsigned               cyc;
  } pend_t;

  logic clock;
  logic rst_n;
  sram_test_pkg::sram_addr_t  host_address;
  sram_test_pkg::sram_be_t    host_byteenable;
  logic                       host_read;
  logic                       host_write;
  sram_test_pkg::sram_word_u  host_writedata;
  sram_test_pkg::sram_word_u  host_readdata;
  logic                       host_readdataready;
  logic                       host_waitrequest;
  logic                       adc_enable;
  logic                       adc_done;
  logic                       adc_busy;
  sram_test_pkg::adc_sample_t adc_data;
  logic                       adc_pwrdwn;
  sram_test_pkg::sram_addr_t  sram_addr;
  sram_test_pkg::sram_word_u  sram_dq_out;
  sram_test_pkg::sram_word_u  sram_dq_in;
  logic                       sram_dq_oe;
  logic                       sram_ce_n;
  logic                       sram_oe_n;
  logic                       sram_we_n;
  sram_test_pkg::sram_be_t    sram_be_n;

  sram_test_pkg::sram_word_u sram_mem [0:(1 << `SRAM_ADDR_W) - 1];
  sram_test_pkg::sram_word_u ref_mem [sram_test_pkg::sram_addr_t];
  sram_test_pkg::sram_addr_t addrs [N_WORDS];
  pend_t       exp_q [$];
  int unsigned cyc = 0;
  int unsigned done_cyc = 0;
  int unsigned errors = 0;
  int unsigned tests = 0;

  tb_clock_gen clk_gen_i (.clock(clock), .rst_n(rst_n));

  sram_test_sys dut_i (.*);

  // async SRAM model, read data follows the pins
  assign sram_dq_in = (!sram_ce_n && !sram_oe_n) ? sram_mem[sram_addr] : 'x;

  // a write lands as its cycle on the pins ends
  always @(posedge clock) begin
    if (!sram_ce_n && !sram_we_n && sram_dq_oe) begin
      if (!sram_be_n[0]) sram_mem[sram_addr].word[7:0] <= sram_dq_out.word[7:0];
      if (!sram_be_n[1]) sram_mem[sram_addr].word[15:8] <= sram_dq_out.word[15:8];
    end
  end

  always @(posedge clock) cyc <= cyc + 1;

  always @(posedge clock) begin : read_monitor
    logic exp_rdy;
    #1;
    exp_rdy = (exp_q.size() != 0) && (exp_q[0].cyc == cyc);
    if (adc_done) done_cyc = cyc;
    if (rst_n) begin
      check_flag("host_readdataready", host_readdataready, exp_rdy);
      if (exp_rdy) begin
        check_word("host_readdata", host_readdata, exp_q[0].data);
        void'(exp_q.pop_front());
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

  task automatic check_word(input string name, input sram_test_pkg::sram_word_u act,
                            input sram_test_pkg::sram_word_u exp);
    if (act !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, act, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, act, exp);
      errors++;
    end
  endtask

  task automatic report_fail(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic end_test(input string name, input int unsigned mark);
    tests++;
    $display("test %0d %s: %0d error(s)", tests, name, errors - mark);
  endtask

  // host tasks start and end in the drive slot 1 ns after an edge
  task automatic host_write_op(input sram_test_pkg::sram_addr_t addr,
                               input sram_test_pkg::sram_be_t be,
                               input sram_test_pkg::sram_word_u data);
    sram_test_pkg::sram_word_u w;
    host_address    = addr;
    host_byteenable = be;
    host_writedata  = data;
    host_write      = 1'b1;
    while (host_waitrequest) begin
      @(posedge clock);
      #1;
    end
    w = ref_mem.exists(addr) ? ref_mem[addr] : '0;
    if (be[0]) w.word[7:0] = data.word[7:0];
    if (be[1]) w.word[15:8] = data.word[15:8];
    ref_mem[addr] = w;
    @(posedge clock);
    #1;
    host_write = 1'b0;
  endtask

  task automatic host_read_op(input sram_test_pkg::sram_addr_t addr, output int unsigned acc);
    host_address = addr;
    host_read    = 1'b1;
    while (host_waitrequest) begin
      @(posedge clock);
      #1;
    end
    acc = cyc + 1;
    // ready is set by the edge after acceptance
    exp_q.push_back(pend_t'{ref_mem[addr], acc + 1});
    @(posedge clock);
    #1;
    host_read = 1'b0;
  endtask

  task automatic wait_reads();
    while (exp_q.size() != 0) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic run_capture(input bit poke, output int unsigned n_smp,
                             output int unsigned n_done);
    sram_test_pkg::adc_sample_t smp [$];
    sram_test_pkg::sram_word_u  w;
    int unsigned k;
    int unsigned tail;
    n_done = 0;
    k = 0;
    tail = 0;
    adc_enable = 1'b1;
    while (tail < 4) begin
      @(posedge clock);
      #1;
      // k counts edges since adc_enable was taken
      check_flag("adc_busy", adc_busy, k < 2 * `CAPTURE_WORDS);
      check_flag("adc_pwrdwn", adc_pwrdwn, k >= 2 * `CAPTURE_WORDS);
      check_flag("adc_done", adc_done, k == 2 * `CAPTURE_WORDS + 1);
      adc_enable = poke && (k == `CAPTURE_WORDS);
      adc_data = 8'($urandom);
      // sampled by the next edge while busy
      if (adc_busy) smp.push_back(adc_data);
      if (adc_done) n_done++;
      if (n_done != 0) tail++;
      k++;
    end
    for (int i = 0; i < smp.size() / 2; i++) begin
      w.pair.lo = smp[2 * i];
      w.pair.hi = smp[2 * i + 1];
      ref_mem[`ADC_BASE_ADDR + sram_test_pkg::sram_addr_t'(i)] = w;
    end
    n_smp = smp.size();
  endtask

  task automatic check_capture(input int unsigned n_smp, input int unsigned n_done);
    if (n_smp != 2 * `CAPTURE_WORDS)
      report_fail($sformatf("capture took %0d samples instead of %0d", n_smp,
                            2 * `CAPTURE_WORDS));
    if (n_done != 1) report_fail($sformatf("saw %0d adc_done pulses instead of one", n_done));
  endtask

  initial begin
    int unsigned mark;
    int unsigned n_smp;
    int unsigned n_done;
    int unsigned acc;
    logic        held;
    void'($urandom(SEED));
    host_address    = '0;
    host_byteenable = '0;
    host_read       = 1'b0;
    host_write      = 1'b0;
    host_writedata  = '0;
    adc_enable      = 1'b0;
    adc_data        = '0;
    wait (rst_n);
    @(posedge clock);
    #1;

    mark = errors;
    check_flag("sram_ce_n", sram_ce_n, 1'b1);
    check_flag("sram_oe_n", sram_oe_n, 1'b1);
    check_flag("sram_we_n", sram_we_n, 1'b1);
    check_flag("sram_dq_oe", sram_dq_oe, 1'b0);
    check_flag("host_readdataready", host_readdataready, 1'b0);
    check_flag("adc_busy", adc_busy, 1'b0);
    check_flag("adc_done", adc_done, 1'b0);
    check_flag("adc_pwrdwn", adc_pwrdwn, 1'b1);
    end_test("reset values", mark);

    // addresses stay below the capture window
    mark = errors;
    for (int i = 0; i < N_WORDS; i++) begin
      addrs[i] = {1'b0, 19'($urandom)};
      host_write_op(addrs[i], 2'b11, 16'($urandom));
    end
    for (int i = 0; i < N_WORDS; i++) host_write_op(addrs[i], 2'($urandom), 16'($urandom));
    for (int i = 0; i < N_WORDS; i++) host_read_op(addrs[i], acc);
    wait_reads();
    end_test("host writes with byte enables", mark);

    mark = errors;
    for (int i = 0; i < N_WORDS; i++) host_read_op(addrs[$urandom % N_WORDS], acc);
    wait_reads();
    end_test("back to back reads", mark);

    mark = errors;
    run_capture(1'b0, n_smp, n_done);
    check_capture(n_smp, n_done);
    for (int i = 0; i < `CAPTURE_WORDS; i++)
      host_read_op(`ADC_BASE_ADDR + sram_test_pkg::sram_addr_t'(i), acc);
    wait_reads();
    end_test("capture and readback", mark);

    mark = errors;
    fork
      run_capture(1'b0, n_smp, n_done);
      begin
        repeat (8) @(posedge clock);
        #1;
        held = host_waitrequest;
        host_read_op(addrs[0], acc);
      end
    join
    wait_reads();
    check_flag("host_waitrequest", held, 1'b1);
    if (acc <= done_cyc) report_fail("held host read was accepted before adc_done");
    end_test("host read held during capture", mark);

    mark = errors;
    run_capture(1'b1, n_smp, n_done);
    check_capture(n_smp, n_done);
    end_test("adc_enable during capture", mark);

    $display("%0d tests run, %0d checks failed", tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sram_test_sys.f
+incdir+logic
logic/sram_test_pkg.sv
logic/sram_bus_if.sv
logic/capture_fsm.sv
logic/sample_counter.sv
logic/sample_packer.sv
logic/sram_arbiter.sv
logic/sram_test_sys.sv
sim/tb_clock_gen.sv
sim/sram_test_sys_properties.sv
sim/sram_test_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run from the project root, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module sram_test_sys_tb \
    -f sram_test_sys.f -o sram_test_sys_sim \
  && ./obj_dir/sram_test_sys_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -qx "Test passed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
